// ==== verilog/pit_pkg.sv ====
package pit_pkg;

	localparam int PREFIX_W = 64;
	localparam int META_W = 8;
	localparam int LEN_W = 6;
	localparam int ROW_W = 6; // 64 table rows
	localparam int ADDR_W = 10;

	localparam int FOLD_SLICES = (PREFIX_W + ROW_W - 1) / ROW_W;

	// Metadata bit that flags repeated data from the FIB side
	localparam int META_REPEAT_BIT = 6;
	localparam logic [1:0] CONSUMER_TAG = 2'b01;

	typedef struct packed {
		logic valid; // Row has been claimed
		logic satisfied; // Data came back for this row
		logic [ADDR_W-1:0] block_addr;
	} pit_entry_t;

	typedef struct packed {
		logic [PREFIX_W-1:0] prefix;
		logic [META_W-1:0] meta;
		logic from_fib;
	} pit_req_t;

	// XOR of all 6-bit slices with the top slice zero padded
	function automatic logic [ROW_W-1:0] fold_hash(input logic [PREFIX_W-1:0] prefix);
		logic [ROW_W*FOLD_SLICES-1:0] padded;
		logic [ROW_W-1:0] acc;
		padded = {{(ROW_W*FOLD_SLICES-PREFIX_W){1'b0}}, prefix};
		acc = '0;
		for (int i = 0; i < FOLD_SLICES; i++) begin
			acc ^= padded[i*ROW_W +: ROW_W];
		end
		return acc;
	endfunction

endpackage

// ==== verilog/pit_req_if.sv ====
interface pit_req_if;

	pit_pkg::pit_req_t req; // Request picked by the arbiter
	logic [pit_pkg::ROW_W-1:0] row; // Hashed row index
	logic start; // One cycle pulse with a new request on req
	logic hash_done; // One cycle pulse when row is valid

	modport arbiter (
		output req,
		output start
	);

	modport hash (
		input req,
		input start,
		output row,
		output hash_done
	);

	modport control (
		input req,
		input row,
		input start,
		input hash_done
	);

endinterface

// ==== verilog/request_arbiter.sv ====
module request_arbiter (
	input logic clk,
	input logic rst,
	input logic out_bit,
	input logic prefix_ready,
	input logic [pit_pkg::PREFIX_W-1:0] spi_prefix,
	input logic [pit_pkg::PREFIX_W-1:0] fib_prefix,
	input logic [pit_pkg::META_W-1:0] fib_meta,
	input logic [pit_pkg::LEN_W-1:0] length,
	input logic ctrl_idle,
	pit_req_if.arbiter req_bus
);

	pit_pkg::pit_req_t fib_slot;
	pit_pkg::pit_req_t con_slot;
	logic fib_full;
	logic con_full;
	logic issue_fib;
	logic issue_con;

	// A start already in flight means the controller has not left idle yet
	assign issue_fib = ctrl_idle && !req_bus.start && fib_full;
	assign issue_con = ctrl_idle && !req_bus.start && !fib_full && con_full; // FIB wins

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fib_full <= 1'b0;
			con_full <= 1'b0;
			req_bus.start <= 1'b0;
		end else begin
			fib_full <= (fib_full && !issue_fib) || prefix_ready;
			con_full <= (con_full && !issue_con) || out_bit;
			req_bus.start <= issue_fib || issue_con;
		end
	end

	// A strobe into a busy slot is dropped
	always_ff @(posedge clk) begin
		if (prefix_ready && (!fib_full || issue_fib)) begin
			fib_slot <= '{prefix: fib_prefix, meta: fib_meta, from_fib: 1'b1};
		end
		if (out_bit && (!con_full || issue_con)) begin
			con_slot <= '{prefix: spi_prefix, meta: {pit_pkg::CONSUMER_TAG, length},
				from_fib: 1'b0};
		end
		if (issue_fib) begin
			req_bus.req <= fib_slot;
		end else if (issue_con) begin
			req_bus.req <= con_slot;
		end
	end

endmodule

// ==== verilog/prefix_hash.sv ====
module prefix_hash (
	input logic clk,
	input logic rst,
	pit_req_if.hash req_bus
);

	localparam int HALF_W = pit_pkg::PREFIX_W / 2;
	localparam int PAD_W = pit_pkg::PREFIX_W - 2 * pit_pkg::ROW_W;

	logic s1_valid;
	logic [pit_pkg::ROW_W-1:0] lo_fold;
	logic [pit_pkg::ROW_W-1:0] hi_fold;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1_valid <= 1'b0;
			req_bus.hash_done <= 1'b0;
		end else begin
			s1_valid <= req_bus.start;
			req_bus.hash_done <= s1_valid;
		end
	end

	// The fold is linear in XOR, so the halves can be folded apart
	always_ff @(posedge clk) begin
		if (req_bus.start) begin
			lo_fold <= pit_pkg::fold_hash({{HALF_W{1'b0}}, req_bus.req.prefix[HALF_W-1:0]});
			hi_fold <= pit_pkg::fold_hash({req_bus.req.prefix[pit_pkg::PREFIX_W-1:HALF_W],
				{HALF_W{1'b0}}});
		end
		// Second stage folds the two slices into the row index
		if (s1_valid) begin
			req_bus.row <= pit_pkg::fold_hash({{PAD_W{1'b0}}, hi_fold, lo_fold});
		end
	end

endmodule

// ==== verilog/pit_entry_store.sv ====
module pit_entry_store (
	input logic clk,
	input logic rst,
	input logic rd_en,
	input logic [pit_pkg::ROW_W-1:0] rd_row,
	input logic wr_en,
	input logic [pit_pkg::ROW_W-1:0] wr_row,
	input pit_pkg::pit_entry_t wr_entry,
	output pit_pkg::pit_entry_t rd_entry
);

	localparam int ROWS = 1 << pit_pkg::ROW_W;

	pit_pkg::pit_entry_t rows [ROWS];

	// All rows clear to invalid on reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < ROWS; i++) begin
				rows[i] <= '0;
			end
			rd_entry <= '0;
		end else begin
			if (wr_en) begin
				rows[wr_row] <= wr_entry;
			end
			if (rd_en) begin
				rd_entry <= rows[rd_row]; // Old value on a same row write
			end
		end
	end

endmodule

// ==== verilog/block_allocator.sv ====
module block_allocator #(
	parameter int BLOCK_SIZE = 1
) (
	input logic clk,
	input logic rst,
	input logic alloc,
	output logic [pit_pkg::ADDR_W-1:0] next_addr,
	output logic exhausted
);

	localparam logic [pit_pkg::ADDR_W:0] STEP = (pit_pkg::ADDR_W + 1)'(BLOCK_SIZE);

	logic [pit_pkg::ADDR_W:0] sum;

	assign sum = {1'b0, next_addr} + STEP; // Carry out means past the top

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			next_addr <= '0;
			exhausted <= 1'b0;
		end else if (alloc && !exhausted) begin
			if (sum[pit_pkg::ADDR_W]) begin
				exhausted <= 1'b1; // Address stays on the last block
			end else begin
				next_addr <= sum[pit_pkg::ADDR_W-1:0];
			end
		end
	end

endmodule

// ==== verilog/pit_control.sv ====
module pit_control (
	input logic clk,
	input logic rst,
	pit_req_if.control req_bus,
	output logic ctrl_idle,
	output logic rd_en,
	output logic [pit_pkg::ROW_W-1:0] rd_row,
	output logic wr_en,
	output logic [pit_pkg::ROW_W-1:0] wr_row,
	output pit_pkg::pit_entry_t wr_entry,
	output logic alloc,
	output logic [pit_pkg::ADDR_W:0] table_entry,
	output logic [pit_pkg::META_W-1:0] meta_data,
	output logic pit_in_bit,
	output logic rejected,
	output logic interest_packet,
	input pit_pkg::pit_entry_t rd_entry,
	input logic [pit_pkg::ADDR_W-1:0] next_addr,
	input logic exhausted
);

	typedef enum logic [1:0] {
		IDLE,
		HASHING,
		LOOKUP,
		DECIDE
	} state_t;

	state_t state;
	state_t state_nxt;
	pit_pkg::pit_req_t req_q;
	logic [pit_pkg::ROW_W-1:0] row_q;
	logic accept;
	logic do_write;
	logic do_alloc;
	logic repeat_hit;
	pit_pkg::pit_entry_t new_entry;
	logic [pit_pkg::ADDR_W:0] result_entry;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (req_bus.start) state_nxt = HASHING;
			HASHING: if (req_bus.hash_done) state_nxt = LOOKUP;
			LOOKUP: state_nxt = DECIDE; // rd_entry is valid here
			DECIDE: state_nxt = IDLE; // Result pulse is on the outputs
			default: state_nxt = IDLE;
		endcase
	end

	// Decision on the entry read back for the request's row
	always_comb begin
		accept = 1'b0;
		do_write = 1'b0;
		do_alloc = 1'b0;
		repeat_hit = 1'b0;
		new_entry = rd_entry;
		result_entry = {rd_entry.satisfied, rd_entry.block_addr};
		if (req_q.from_fib) begin
			if (rd_entry.valid) begin
				accept = 1'b1;
				do_write = 1'b1;
				new_entry.satisfied = 1'b1;
				repeat_hit = req_q.meta[pit_pkg::META_REPEAT_BIT] && rd_entry.satisfied;
				result_entry = {1'b1, rd_entry.block_addr};
			end
		end else if (rd_entry.valid) begin
			accept = 1'b1; // Existing entry returned as is
		end else if (!exhausted) begin
			accept = 1'b1;
			do_write = 1'b1;
			do_alloc = 1'b1;
			new_entry = '{valid: 1'b1, satisfied: 1'b0, block_addr: next_addr};
			result_entry = {1'b0, next_addr};
		end
	end

	assign ctrl_idle = (state == IDLE);
	assign rd_en = (state == HASHING) && req_bus.hash_done;
	assign rd_row = req_bus.row;
	assign wr_en = (state == LOOKUP) && do_write;
	assign wr_row = row_q;
	assign wr_entry = new_entry;
	assign alloc = (state == LOOKUP) && do_alloc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			pit_in_bit <= 1'b0;
			rejected <= 1'b0;
			interest_packet <= 1'b0;
			table_entry <= '0;
			meta_data <= '0;
		end else begin
			state <= state_nxt;
			pit_in_bit <= 1'b0;
			rejected <= 1'b0;
			interest_packet <= 1'b0;
			if (state == LOOKUP) begin
				pit_in_bit <= accept;
				rejected <= !accept;
				interest_packet <= repeat_hit;
				table_entry <= accept ? result_entry : '0;
				meta_data <= req_q.meta;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_idle && req_bus.start) begin
			req_q <= req_bus.req;
		end
		if (rd_en) begin
			row_q <= req_bus.row; // Kept for the write back
		end
	end

endmodule

// ==== verilog/pit_hash_table.sv ====
module pit_hash_table #(
	parameter int BLOCK_SIZE = 1
) (
	input logic clk,
	input logic rst,
	input logic [pit_pkg::PREFIX_W-1:0] spi_prefix,
	input logic [pit_pkg::PREFIX_W-1:0] fib_prefix,
	input logic [pit_pkg::META_W-1:0] fib_meta,
	input logic [pit_pkg::LEN_W-1:0] length,
	input logic prefix_ready,
	input logic out_bit,
	output logic [pit_pkg::ADDR_W:0] table_entry,
	output logic [pit_pkg::META_W-1:0] meta_data,
	output logic pit_in_bit,
	output logic rejected,
	output logic interest_packet
);

	logic ctrl_idle;
	logic rd_en;
	logic [pit_pkg::ROW_W-1:0] rd_row;
	logic wr_en;
	logic [pit_pkg::ROW_W-1:0] wr_row;
	pit_pkg::pit_entry_t wr_entry;
	pit_pkg::pit_entry_t rd_entry;
	logic alloc;
	logic [pit_pkg::ADDR_W-1:0] next_addr;
	logic exhausted;

	pit_req_if req_bus ();

	request_arbiter u_request_arbiter (
		.clk(clk),
		.rst(rst),
		.out_bit(out_bit),
		.prefix_ready(prefix_ready),
		.spi_prefix(spi_prefix),
		.fib_prefix(fib_prefix),
		.fib_meta(fib_meta),
		.length(length),
		.ctrl_idle(ctrl_idle),
		.req_bus(req_bus.arbiter)
	);

	prefix_hash u_prefix_hash (
		.clk(clk),
		.rst(rst),
		.req_bus(req_bus.hash)
	);

	pit_entry_store u_pit_entry_store (
		.clk(clk),
		.rst(rst),
		.rd_en(rd_en),
		.rd_row(rd_row),
		.wr_en(wr_en),
		.wr_row(wr_row),
		.wr_entry(wr_entry),
		.rd_entry(rd_entry)
	);

	block_allocator #(
		.BLOCK_SIZE(BLOCK_SIZE)
	) u_block_allocator (
		.clk(clk),
		.rst(rst),
		.alloc(alloc),
		.next_addr(next_addr),
		.exhausted(exhausted)
	);

	pit_control u_pit_control (
		.clk(clk),
		.rst(rst),
		.req_bus(req_bus.control),
		.ctrl_idle(ctrl_idle),
		.rd_en(rd_en),
		.rd_row(rd_row),
		.wr_en(wr_en),
		.wr_row(wr_row),
		.wr_entry(wr_entry),
		.alloc(alloc),
		.table_entry(table_entry),
		.meta_data(meta_data),
		.pit_in_bit(pit_in_bit),
		.rejected(rejected),
		.interest_packet(interest_packet),
		.rd_entry(rd_entry),
		.next_addr(next_addr),
		.exhausted(exhausted)
	);

endmodule

// ==== tb/pit_tests.svh ====
`ifndef PIT_TESTS_SVH
`define PIT_TESTS_SVH

logic [63:0] first_prefix; // First claimed row that the repeat interest reuses
logic [63:0] satisfied_prefix; // Row that has seen FIB data

task automatic test_reset_values;
	check_eq("table_entry", table_entry, '0);
	check_eq("meta_data", meta_data, '0);
	check_eq("pit_in_bit", pit_in_bit, 1'b0);
	check_eq("rejected", rejected, 1'b0);
	check_eq("interest_packet", interest_packet, 1'b0);
endtask

task automatic test_new_claims;
	logic [63:0] p;
	logic [pit_pkg::ADDR_W:0] e;
	fresh_prefix(first_prefix);
	consumer_request(first_prefix, 6'd17, e);
	check_eq("first claim table_entry", e, 0); // Unsatisfied entry on block 0
	fresh_prefix(p);
	consumer_request(p, 6'd5, e);
	check_eq("second claim table_entry", e, BLOCK_SIZE);
endtask

task automatic test_repeat_interest;
	logic [63:0] p;
	logic [pit_pkg::ADDR_W:0] e;
	consumer_request(first_prefix, 6'd33, e);
	check_eq("repeat interest table_entry", e, 0);
	// Allocator must not have moved on the repeat
	fresh_prefix(p);
	consumer_request(p, 6'd9, e);
	check_eq("third claim table_entry", e, 2 * BLOCK_SIZE);
endtask

task automatic test_fib_empty_row;
	logic [63:0] p;
	fresh_prefix(p);
	fib_request(p, 8'h3c);
	check_eq("rejected on empty row", rejected, 1'b1);
	check_eq("meta_data echo", meta_data, 8'h3c);
endtask

task automatic test_fib_claimed_row;
	logic [63:0] p;
	logic [63:0] alias_p;
	logic [pit_pkg::ADDR_W:0] e;
	fresh_prefix(p);
	consumer_request(p, 6'd12, e);
	fib_request(p, 8'h00);
	check_eq("satisfied bit", table_entry[pit_pkg::ADDR_W], 1'b1);
	check_eq("interest_packet first data", interest_packet, 1'b0);
	fib_request(p, 8'h40); // Repeat flag on a satisfied row
	check_eq("interest_packet on repeat", interest_packet, 1'b1);
	// Flips at bits 0 and 60 and at bits 31 and 37 cancel in the fold
	alias_p = p ^ 64'h1000_0020_8000_0001;
	fib_request(alias_p, 8'h81);
	check_eq("interest_packet without flag", interest_packet, 1'b0);
	satisfied_prefix = p;
endtask

task automatic test_simultaneous;
	logic [63:0] cp;
	logic accept;
	logic ip;
	logic [pit_pkg::ADDR_W:0] exp_entry;
	fresh_prefix(cp);
	@(posedge clk);
	#10;
	fib_prefix = satisfied_prefix;
	fib_meta = 8'h47;
	prefix_ready = 1'b1;
	spi_prefix = cp;
	length = 6'd21;
	out_bit = 1'b1;
	await_result();
	model_fib(satisfied_prefix, 8'h47, accept, exp_entry, ip);
	check_result(accept, exp_entry, 8'h47, ip); // FIB goes first
	// Controller is idle one edge after the pulse and the consumer result comes 5 edges later
	for (int i = 1; i <= 6; i++) begin
		@(posedge clk);
		#10;
		if (i < 6) begin
			check_eq("pit_in_bit before consumer result", pit_in_bit, 1'b0);
			check_eq("rejected before consumer result", rejected, 1'b0);
		end
	end
	check_single_pulse();
	model_consumer(cp, accept, exp_entry, ip);
	check_result(accept, exp_entry, {2'b01, 6'd21}, ip);
endtask

`endif

// ==== tb/tb_pit.sv ====
module tb_pit;

	localparam int BLOCK_SIZE = 1;
	localparam int PERIOD = 100;
	localparam int NUM_REQUESTS = 11; // Requests issued over all directed tests
	localparam int ROWS = 1 << pit_pkg::ROW_W;

	logic clk;
	logic rst;
	logic [pit_pkg::PREFIX_W-1:0] spi_prefix;
	logic [pit_pkg::PREFIX_W-1:0] fib_prefix;
	logic [pit_pkg::META_W-1:0] fib_meta;
	logic [pit_pkg::LEN_W-1:0] length;
	logic prefix_ready;
	logic out_bit;
	logic [pit_pkg::ADDR_W:0] table_entry;
	logic [pit_pkg::META_W-1:0] meta_data;
	logic pit_in_bit;
	logic rejected;
	logic interest_packet;

	// Reference model of the table
	logic model_valid [ROWS];
	logic model_sat [ROWS];
	logic [pit_pkg::ADDR_W-1:0] model_addr [ROWS];
	logic [pit_pkg::ADDR_W-1:0] model_next;
	logic model_exhausted;
	logic [31:0] lcg_state;

	pit_hash_table #(
		.BLOCK_SIZE(BLOCK_SIZE)
	) u_pit_hash_table (
		.clk(clk),
		.rst(rst),
		.spi_prefix(spi_prefix),
		.fib_prefix(fib_prefix),
		.fib_meta(fib_meta),
		.length(length),
		.prefix_ready(prefix_ready),
		.out_bit(out_bit),
		.table_entry(table_entry),
		.meta_data(meta_data),
		.pit_in_bit(pit_in_bit),
		.rejected(rejected),
		.interest_packet(interest_packet)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_eq(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch at %0t: %s is %0h, expected %0h", $time, name,
				actual, expected));
		end
	endtask

	initial begin
		#((NUM_REQUESTS * 10 + 50) * PERIOD);
		fail_run("watchdog timeout, the tests did not finish in time");
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// XOR of 6-bit slices from bit 0 up with a short top slice
	function automatic logic [pit_pkg::ROW_W-1:0] model_row(input logic [63:0] prefix);
		logic [pit_pkg::ROW_W-1:0] acc;
		acc = '0;
		for (int i = 0; i < 64; i += 6) begin
			acc ^= pit_pkg::ROW_W'(prefix >> i);
		end
		return acc;
	endfunction

	task automatic next_prefix(output logic [63:0] p);
		lcg_state = lcg_next(lcg_state);
		p[63:32] = lcg_state;
		lcg_state = lcg_next(lcg_state);
		p[31:0] = lcg_state;
	endtask

	// Prefix whose row is still empty in the model
	task automatic fresh_prefix(output logic [63:0] p);
		int tries;
		tries = 0;
		do begin
			next_prefix(p);
			tries++;
		end while (model_valid[model_row(p)] && tries < 1000);
		if (model_valid[model_row(p)]) fail_run("no prefix with an empty row was found");
	endtask

	task automatic model_consumer(input logic [63:0] prefix, output logic accept,
		output logic [pit_pkg::ADDR_W:0] entry, output logic ip);
		logic [pit_pkg::ROW_W-1:0] row;
		row = model_row(prefix);
		ip = 1'b0;
		accept = 1'b1;
		if (model_valid[row]) begin
			entry = {model_sat[row], model_addr[row]};
		end else if (!model_exhausted) begin
			model_valid[row] = 1'b1;
			model_sat[row] = 1'b0;
			model_addr[row] = model_next;
			entry = {1'b0, model_next};
			if (int'(model_next) + BLOCK_SIZE >= (1 << pit_pkg::ADDR_W)) begin
				model_exhausted = 1'b1;
			end else begin
				model_next = model_next + BLOCK_SIZE;
			end
		end else begin
			accept = 1'b0; // Out of blocks
			entry = '0;
		end
	endtask

	task automatic model_fib(input logic [63:0] prefix, input logic [7:0] meta,
		output logic accept, output logic [pit_pkg::ADDR_W:0] entry, output logic ip);
		logic [pit_pkg::ROW_W-1:0] row;
		row = model_row(prefix);
		accept = model_valid[row];
		ip = model_valid[row] && meta[6] && model_sat[row];
		entry = model_valid[row] ? {1'b1, model_addr[row]} : '0;
		if (model_valid[row]) model_sat[row] = 1'b1;
	endtask

	task automatic drive_consumer(input logic [63:0] prefix, input logic [5:0] len);
		@(posedge clk);
		#10;
		spi_prefix = prefix;
		length = len;
		out_bit = 1'b1;
	endtask

	task automatic drive_fib(input logic [63:0] prefix, input logic [7:0] meta);
		@(posedge clk);
		#10;
		fib_prefix = prefix;
		fib_meta = meta;
		prefix_ready = 1'b1;
	endtask

	task automatic check_single_pulse;
		if (pit_in_bit === rejected) begin
			fail_run($sformatf(
				"at %0t exactly one of pit_in_bit and rejected should be high, saw %b and %b",
				$time, pit_in_bit, rejected));
		end
	endtask

	// Result lands on the sixth edge after the strobe edge
	task automatic await_result;
		@(posedge clk);
		#10;
		out_bit = 1'b0;
		prefix_ready = 1'b0;
		repeat (5) @(posedge clk);
		#10;
		check_single_pulse();
	endtask

	task automatic check_result(input logic accept, input logic [pit_pkg::ADDR_W:0] entry,
		input logic [7:0] meta, input logic ip);
		check_eq("pit_in_bit", pit_in_bit, accept);
		check_eq("rejected", rejected, !accept);
		check_eq("table_entry", table_entry, entry);
		check_eq("meta_data", meta_data, meta);
		check_eq("interest_packet", interest_packet, ip);
	endtask

	task automatic consumer_request(input logic [63:0] prefix, input logic [5:0] len,
		output logic [pit_pkg::ADDR_W:0] entry);
		logic accept;
		logic ip;
		logic [pit_pkg::ADDR_W:0] exp_entry;
		drive_consumer(prefix, len);
		await_result();
		model_consumer(prefix, accept, exp_entry, ip);
		check_result(accept, exp_entry, {2'b01, len}, ip); // Tag above the length
		entry = table_entry;
	endtask

	task automatic fib_request(input logic [63:0] prefix, input logic [7:0] meta);
		logic accept;
		logic ip;
		logic [pit_pkg::ADDR_W:0] exp_entry;
		drive_fib(prefix, meta);
		await_result();
		model_fib(prefix, meta, accept, exp_entry, ip);
		check_result(accept, exp_entry, meta, ip);
	endtask

	`include "pit_tests.svh"

	initial begin
		rst = 1'b1;
		out_bit = 1'b0;
		prefix_ready = 1'b0;
		spi_prefix = '0;
		fib_prefix = '0;
		fib_meta = '0;
		length = '0;
		lcg_state = 32'hb3ab_fb64;
		for (int i = 0; i < ROWS; i++) begin
			model_valid[i] = 1'b0;
			model_sat[i] = 1'b0;
			model_addr[i] = '0;
		end
		model_next = '0;
		model_exhausted = 1'b0;
		repeat (2) @(posedge clk);
		#10;
		rst = 1'b0;
		test_reset_values();
		test_new_claims();
		test_repeat_interest();
		test_fib_empty_row();
		test_fib_claimed_row();
		test_simultaneous();
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+tb
verilog/pit_pkg.sv
verilog/pit_req_if.sv
verilog/request_arbiter.sv
verilog/prefix_hash.sv
verilog/pit_entry_store.sv
verilog/block_allocator.sv
verilog/pit_control.sv
verilog/pit_hash_table.sv
tb/tb_pit.sv
